// File: src/epu_pkg.sv
package epu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int DATA_W      = 32;
   // Instructions are word aligned
   localparam int INSN_LSB    = 2;
   localparam int PC_W        = DATA_W - INSN_LSB;
   localparam int PSR_W       = 6;
   localparam int EXCP_VECT_W = 8;
   localparam int EVECT_W     = DATA_W - EXCP_VECT_W;
   localparam int CAUSE_W     = 5;
   localparam int MSR_WE_W    = 5;

   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [PC_W-1:0]     pc_t;
   typedef logic [PSR_W-1:0]    psr_t;
   typedef logic [EVECT_W-1:0]  evect_t;
   typedef logic [CAUSE_W-1:0]  cause_t;
   typedef logic [MSR_WE_W-1:0] msr_we_t;

   // PSR fields, rm in bit 0
   localparam int PSR_RM   = 0;
   localparam int PSR_IRE  = 1;
   localparam int PSR_IMME = 2;
   localparam int PSR_DMME = 3;
   localparam int PSR_ICE  = 4;
   localparam int PSR_DCE  = 5;
   // Where the PSR fields sit in an MSR data word
   localparam int PSR_LSB  = 4;
   localparam psr_t PSR_RESET = psr_t'(1 << PSR_RM);

   ////////////////////////////////////////////////////////////////////////////
   // MSR address map
   ////////////////////////////////////////////////////////////////////////////

   // Bank number above a one-hot offset field
   localparam int MSR_OFF_AW  = 9;
   localparam int MSR_BANK_AW = 3;
   localparam int MSR_BANK_PS = 0;

   localparam int MSR_PSR   = 0;
   localparam int MSR_EPSR  = 1;
   localparam int MSR_EPC   = 2;
   localparam int MSR_ELSA  = 3;
   localparam int MSR_EVECT = 4;

   // One-hot exception causes
   localparam int CAUSE_ERET    = 0;
   localparam int CAUSE_SYSCALL = 1;
   localparam int CAUSE_EINSN   = 2;
   localparam int CAUSE_EIRQ    = 3;
   localparam int CAUSE_EALIGN  = 4;

endpackage

// File: src/epu_commit_if.sv
`timescale 1ns/100ps

interface epu_commit_if;
   import epu_pkg::*;

   // Committed request, gated by the stage-two enable
   cause_t  commit_cause;
   msr_we_t commit_we;
   data_t   commit_wdat;
   pc_t     commit_pc;
   pc_t     commit_npc;
   logic    psr_save;
   logic    psr_restore;

   // Next values of EPC and ELSA
   data_t   epc_nxt;
   logic    epc_we;
   data_t   elsa_nxt;
   logic    elsa_we;

   modport ctrl (output commit_cause, commit_we, commit_wdat, commit_pc, commit_npc,
                 output psr_save, psr_restore);

   modport addr (input commit_cause, commit_we, commit_wdat, commit_pc, commit_npc,
                 input psr_save,
                 output epc_nxt, epc_we, elsa_nxt, elsa_we);

   modport regs (input commit_cause, commit_we, commit_wdat, commit_pc, commit_npc,
                 input psr_save, psr_restore, epc_nxt, epc_we, elsa_nxt, elsa_we);

endinterface

// File: src/epu_msr_if.sv
`timescale 1ns/100ps

interface epu_msr_if;
   import epu_pkg::*;

   // Current exception register values
   psr_t   psr;
   psr_t   epsr;
   data_t  epc;
   data_t  elsa;
   evect_t evect;

   // Driven by the register bank
   modport regs (output psr, epsr, epc, elsa, evect);

   // Read-only view for decode and address selection
   modport reader (input psr, epsr, epc, elsa, evect);

endinterface

// File: src/epu_msr_decode.sv
`timescale 1ns/100ps

module epu_msr_decode
(
   input  logic              cmt_req_valid,
   input  logic              cmt_wmsr,
   input  epu_pkg::data_t    cmt_addr,
   epu_msr_if.reader         msr,
   output epu_pkg::data_t    rd_data,
   output epu_pkg::msr_we_t  wr_we
);
   import epu_pkg::*;

   logic [MSR_BANK_AW-1:0] bank_addr;
   logic [MSR_OFF_AW-1:0]  bank_off;
   logic                   bank_ps;
   logic                   wmsr_ps;
   data_t                  psr_word;
   data_t                  epsr_word;
   data_t                  evect_word;
   data_t                  dout_ps;

   ////////////////////////////////////////////////////////////////////////////
   // Address split
   ////////////////////////////////////////////////////////////////////////////

   assign bank_addr = cmt_addr[MSR_BANK_AW+MSR_OFF_AW-1:MSR_OFF_AW];
   assign bank_off  = cmt_addr[MSR_OFF_AW-1:0];
   assign bank_ps   = (bank_addr == MSR_BANK_AW'(MSR_BANK_PS));

   ////////////////////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////////////////////

   // PSR and EPSR read back at bits 9:4
   assign psr_word  = {{(DATA_W-PSR_W-PSR_LSB){1'b0}}, msr.psr, {PSR_LSB{1'b0}}};
   assign epsr_word = {{(DATA_W-PSR_W-PSR_LSB){1'b0}}, msr.epsr, {PSR_LSB{1'b0}}};

   // Vector base occupies the upper bits only
   assign evect_word = {msr.evect, {EXCP_VECT_W{1'b0}}};

   // Offset is one-hot, so an AND-OR is enough
   assign dout_ps =
      ({DATA_W{bank_off[MSR_PSR]}}   & psr_word)   |
      ({DATA_W{bank_off[MSR_EPSR]}}  & epsr_word)  |
      ({DATA_W{bank_off[MSR_EPC]}}   & msr.epc)    |
      ({DATA_W{bank_off[MSR_ELSA]}}  & msr.elsa)   |
      ({DATA_W{bank_off[MSR_EVECT]}} & evect_word);

   // Other banks read as zero
   assign rd_data = bank_ps ? dout_ps : '0;

   ////////////////////////////////////////////////////////////////////////////
   // Write-enable decode
   ////////////////////////////////////////////////////////////////////////////

   assign wmsr_ps = cmt_req_valid & cmt_wmsr & bank_ps;

   always_comb
   begin
      for (int i = 0; i < MSR_WE_W; i++)
      begin
         wr_we[i] = wmsr_ps & bank_off[i];
      end
   end

endmodule

// File: src/epu_commit_ctrl.sv
`timescale 1ns/100ps

module epu_commit_ctrl
(
   input  logic              clk,
   input  logic              reset,
   input  logic              p_ce_s1,
   input  logic              p_ce_s2,
   input  logic              cmt_req_valid,
   input  logic              cmt_exc,
   input  logic              cmt_rmsr,
   input  epu_pkg::cause_t   cmt_fe,
   input  epu_pkg::pc_t      cmt_pc,
   input  epu_pkg::pc_t      cmt_npc,
   input  epu_pkg::data_t    cmt_wdat,
   input  epu_pkg::msr_we_t  wr_we,
   input  epu_pkg::data_t    rd_data,
   input  logic              s3i_ealign,
   epu_commit_if.ctrl        commit,
   output epu_pkg::data_t    epu_wb_dout,
   output logic              epu_wb_dout_sel,
   output logic              epu_wb_valid,
   output logic              exc_flush,
   output logic              refetch
);
   import epu_pkg::*;

   cause_t  s1i_cause;
   logic    s1o_valid;
   cause_t  s1o_cause;
   msr_we_t s1o_we;
   data_t   s1o_wdat;
   pc_t     s1o_pc;
   pc_t     s1o_npc;
   data_t   s1o_rd_data;
   logic    s1o_rd_sel;
   cause_t  cmt_cause;
   msr_we_t cmt_we;

   // Instruction causes only, EALIGN arrives later from stage three
   always_comb
   begin
      s1i_cause = cmt_fe & {CAUSE_W{cmt_req_valid & cmt_exc}};
      s1i_cause[CAUSE_EALIGN] = 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stage-one register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         s1o_valid  <= 1'b0;
         s1o_cause  <= '0;
         s1o_we     <= '0;
         s1o_rd_sel <= 1'b0;
      end
      else if (p_ce_s1)
      begin
         s1o_valid  <= cmt_req_valid;
         s1o_cause  <= s1i_cause;
         s1o_we     <= wr_we;
         s1o_rd_sel <= cmt_req_valid & cmt_rmsr;
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      if (p_ce_s1)
      begin
         s1o_wdat    <= cmt_wdat;
         s1o_pc      <= cmt_pc;
         s1o_npc     <= cmt_npc;
         s1o_rd_data <= rd_data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Commit cycle
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      cmt_cause = s1o_cause;
      cmt_cause[CAUSE_EALIGN] = s3i_ealign;
      cmt_cause = cmt_cause & {CAUSE_W{p_ce_s2}};
   end

   assign cmt_we = s1o_we & {MSR_WE_W{p_ce_s2}};

   assign commit.commit_cause = cmt_cause;
   assign commit.commit_we    = cmt_we;
   assign commit.commit_wdat  = s1o_wdat;
   assign commit.commit_pc    = s1o_pc;
   assign commit.commit_npc   = s1o_npc;

   // Every cause but ERET saves PSR
   assign commit.psr_save    = |(cmt_cause & ~cause_t'(1 << CAUSE_ERET));
   assign commit.psr_restore = cmt_cause[CAUSE_ERET];

   assign exc_flush = |cmt_cause;

   // Mode change, so the front end must refetch
   assign refetch = cmt_we[MSR_PSR];

   assign epu_wb_valid    = s1o_valid & p_ce_s2;
   assign epu_wb_dout     = s1o_rd_data;
   assign epu_wb_dout_sel = s1o_rd_sel;

endmodule

// File: src/epu_excp_regs.sv
`timescale 1ns/100ps

module epu_excp_regs
(
   input  logic           clk,
   input  logic           reset,
   epu_commit_if.regs     commit,
   epu_msr_if.regs        msr,
   output epu_pkg::psr_t  msr_psr
);
   import epu_pkg::*;

   psr_t   psr_q;
   psr_t   epsr_q;
   data_t  epc_q;
   data_t  elsa_q;
   evect_t evect_q;
   psr_t   wdat_psr;

   // PSR field layout in the write data
   assign wdat_psr = commit.commit_wdat[PSR_LSB +: PSR_W];

   ////////////////////////////////////////////////////////////////////////////
   // PSR and EPSR
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         psr_q  <= PSR_RESET;
         epsr_q <= '0;
      end
      else if (commit.psr_save)
      begin
         // Enter kernel mode, caches keep their state
         epsr_q           <= psr_q;
         psr_q[PSR_RM]    <= 1'b1;
         psr_q[PSR_IRE]   <= 1'b0;
         psr_q[PSR_IMME]  <= 1'b0;
         psr_q[PSR_DMME]  <= 1'b0;
      end
      else if (commit.psr_restore)
      begin
         psr_q <= epsr_q;
      end
      else
      begin
         if (commit.commit_we[MSR_PSR])
            psr_q <= wdat_psr;
         if (commit.commit_we[MSR_EPSR])
            epsr_q <= wdat_psr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // EVECT, EPC and ELSA
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         evect_q <= '0;
         epc_q   <= '0;
         elsa_q  <= '0;
      end
      else
      begin
         if (commit.commit_we[MSR_EVECT])
            evect_q <= commit.commit_wdat[DATA_W-1:EXCP_VECT_W];
         if (commit.epc_we)
            epc_q <= commit.epc_nxt;
         if (commit.elsa_we)
            elsa_q <= commit.elsa_nxt;
      end
   end

   assign msr.psr   = psr_q;
   assign msr.epsr  = epsr_q;
   assign msr.epc   = epc_q;
   assign msr.elsa  = elsa_q;
   assign msr.evect = evect_q;
   assign msr_psr   = psr_q;

endmodule

// File: src/epu_excp_addr.sv
`timescale 1ns/100ps

module epu_excp_addr
#(
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] SYSCALL_VECTOR = 8'h00,
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] EINSN_VECTOR   = 8'h40,
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] EIRQ_VECTOR    = 8'h80,
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] EALIGN_VECTOR  = 8'hC0
)
(
   epu_commit_if.addr      commit,
   epu_msr_if.reader       msr,
   input  epu_pkg::data_t  s3i_vaddr,
   output epu_pkg::pc_t    exc_flush_tgt
);
   import epu_pkg::*;

   cause_t cause;
   data_t  pc_addr;
   data_t  npc_addr;

   // Vector base followed by the word bits of the offset
   function automatic pc_t vect_tgt(input evect_t base, input logic [EXCP_VECT_W-1:0] vect);
      return {base, vect[EXCP_VECT_W-1:INSN_LSB]};
   endfunction

   assign cause    = commit.commit_cause;
   assign pc_addr  = {commit.commit_pc, {INSN_LSB{1'b0}}};
   assign npc_addr = {commit.commit_npc, {INSN_LSB{1'b0}}};

   // At most one cause is set per commit
   assign exc_flush_tgt =
      ({PC_W{cause[CAUSE_ERET]}}    & msr.epc[DATA_W-1:INSN_LSB])         |
      ({PC_W{cause[CAUSE_SYSCALL]}} & vect_tgt(msr.evect, SYSCALL_VECTOR)) |
      ({PC_W{cause[CAUSE_EINSN]}}   & vect_tgt(msr.evect, EINSN_VECTOR))   |
      ({PC_W{cause[CAUSE_EIRQ]}}    & vect_tgt(msr.evect, EIRQ_VECTOR))    |
      ({PC_W{cause[CAUSE_EALIGN]}}  & vect_tgt(msr.evect, EALIGN_VECTOR));

   // Syscall returns past itself, the others retry
   assign commit.epc_nxt = commit.commit_we[MSR_EPC]  ? commit.commit_wdat :
                           cause[CAUSE_SYSCALL]        ? npc_addr : pc_addr;
   assign commit.epc_we  = commit.psr_save | commit.commit_we[MSR_EPC];

   // Faulting address for EINSN and EALIGN
   assign commit.elsa_nxt = cause[CAUSE_EINSN]  ? pc_addr   :
                            cause[CAUSE_EALIGN] ? s3i_vaddr : commit.commit_wdat;
   assign commit.elsa_we  = cause[CAUSE_EINSN] | cause[CAUSE_EALIGN] |
                            commit.commit_we[MSR_ELSA];

endmodule

// File: src/epu_top.sv
`timescale 1ns/100ps

module epu_top
#(
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] SYSCALL_VECTOR = 8'h00,
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] EINSN_VECTOR   = 8'h40,
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] EIRQ_VECTOR    = 8'h80,
   parameter logic [epu_pkg::EXCP_VECT_W-1:0] EALIGN_VECTOR  = 8'hC0
)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             p_ce_s1,
   input  logic             p_ce_s2,
   input  logic             cmt_req_valid,
   input  logic             cmt_exc,
   input  logic             cmt_rmsr,
   input  logic             cmt_wmsr,
   input  logic             s3i_ealign,
   input  epu_pkg::cause_t  cmt_fe,
   input  epu_pkg::pc_t     cmt_pc,
   input  epu_pkg::pc_t     cmt_npc,
   input  epu_pkg::data_t   cmt_addr,
   input  epu_pkg::data_t   cmt_wdat,
   input  epu_pkg::data_t   s3i_vaddr,
   // Writeback
   output epu_pkg::data_t   epu_wb_dout,
   output logic             epu_wb_dout_sel,
   output logic             epu_wb_valid,
   // Flush
   output logic             exc_flush,
   output logic             refetch,
   output epu_pkg::pc_t     exc_flush_tgt,
   output epu_pkg::psr_t    msr_psr
);
   import epu_pkg::*;

   data_t   rd_data;
   msr_we_t wr_we;

   epu_commit_if commit_bus ();
   epu_msr_if    msr_bus ();

   // Stage-one decode and read
   epu_msr_decode u_msr_decode
   (
      .cmt_req_valid (cmt_req_valid),
      .cmt_wmsr      (cmt_wmsr),
      .cmt_addr      (cmt_addr),
      .msr           (msr_bus.reader),
      .rd_data       (rd_data),
      .wr_we         (wr_we)
   );

   epu_commit_ctrl u_commit_ctrl
   (
      .clk             (clk),
      .reset           (reset),
      .p_ce_s1         (p_ce_s1),
      .p_ce_s2         (p_ce_s2),
      .cmt_req_valid   (cmt_req_valid),
      .cmt_exc         (cmt_exc),
      .cmt_rmsr        (cmt_rmsr),
      .cmt_fe          (cmt_fe),
      .cmt_pc          (cmt_pc),
      .cmt_npc         (cmt_npc),
      .cmt_wdat        (cmt_wdat),
      .wr_we           (wr_we),
      .rd_data         (rd_data),
      .s3i_ealign      (s3i_ealign),
      .commit          (commit_bus.ctrl),
      .epu_wb_dout     (epu_wb_dout),
      .epu_wb_dout_sel (epu_wb_dout_sel),
      .epu_wb_valid    (epu_wb_valid),
      .exc_flush       (exc_flush),
      .refetch         (refetch)
   );

   epu_excp_addr
   #(
      .SYSCALL_VECTOR (SYSCALL_VECTOR),
      .EINSN_VECTOR   (EINSN_VECTOR),
      .EIRQ_VECTOR    (EIRQ_VECTOR),
      .EALIGN_VECTOR  (EALIGN_VECTOR)
   )
   u_excp_addr
   (
      .commit        (commit_bus.addr),
      .msr           (msr_bus.reader),
      .s3i_vaddr     (s3i_vaddr),
      .exc_flush_tgt (exc_flush_tgt)
   );

   epu_excp_regs u_excp_regs
   (
      .clk     (clk),
      .reset   (reset),
      .commit  (commit_bus.regs),
      .msr     (msr_bus.regs),
      .msr_psr (msr_psr)
   );

endmodule

// File: bench/epu_tb.sv
`timescale 1ns/100ps

module epu_tb;
   import epu_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int NUM_DIRECTED = 31;
   localparam int NUM_RANDOM   = 40;
   localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
   localparam int WATCH_CYCLES = 10 + NUM_OPS * 20;

   // Non-default vectors, so the parameters must reach the datapath
   localparam logic [7:0] SYSCALL_V = 8'h20;
   localparam logic [7:0] EINSN_V   = 8'h44;
   localparam logic [7:0] EIRQ_V    = 8'h88;
   localparam logic [7:0] EALIGN_V  = 8'hCC;

   typedef struct packed {
      psr_t   psr;
      psr_t   epsr;
      data_t  epc;
      data_t  elsa;
      evect_t evect;
   } msr_state_t;

   typedef struct packed {
      logic   rmsr;
      logic   wmsr;
      data_t  addr;
      data_t  wdat;
      cause_t cause;
      pc_t    pc;
      pc_t    npc;
      data_t  vaddr;
   } op_t;

   typedef struct packed {
      logic       dout_sel;
      data_t      dout;
      logic       flush;
      pc_t        tgt;
      logic       refetch;
      msr_state_t nxt;
   } expect_t;

   logic    clk = 1'b0;
   logic    reset;
   logic    p_ce_s1;
   logic    p_ce_s2;
   logic    cmt_req_valid;
   logic    cmt_exc;
   logic    cmt_rmsr;
   logic    cmt_wmsr;
   logic    s3i_ealign;
   cause_t  cmt_fe;
   pc_t     cmt_pc;
   pc_t     cmt_npc;
   data_t   cmt_addr;
   data_t   cmt_wdat;
   data_t   s3i_vaddr;
   data_t   epu_wb_dout;
   logic    epu_wb_dout_sel;
   logic    epu_wb_valid;
   logic    exc_flush;
   logic    refetch;
   pc_t     exc_flush_tgt;
   psr_t    msr_psr;

   msr_state_t model;
   expect_t    expect_q;
   logic       in_commit;
   int         errors = 0;
   int         checks = 0;
   int         commits = 0;
   int         requests = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   epu_top
   #(
      .SYSCALL_VECTOR (SYSCALL_V),
      .EINSN_VECTOR   (EINSN_V),
      .EIRQ_VECTOR    (EIRQ_V),
      .EALIGN_VECTOR  (EALIGN_V)
   )
   epu_top_i
   (
      .clk             (clk),
      .reset           (reset),
      .p_ce_s1         (p_ce_s1),
      .p_ce_s2         (p_ce_s2),
      .cmt_req_valid   (cmt_req_valid),
      .cmt_exc         (cmt_exc),
      .cmt_rmsr        (cmt_rmsr),
      .cmt_wmsr        (cmt_wmsr),
      .s3i_ealign      (s3i_ealign),
      .cmt_fe          (cmt_fe),
      .cmt_pc          (cmt_pc),
      .cmt_npc         (cmt_npc),
      .cmt_addr        (cmt_addr),
      .cmt_wdat        (cmt_wdat),
      .s3i_vaddr       (s3i_vaddr),
      .epu_wb_dout     (epu_wb_dout),
      .epu_wb_dout_sel (epu_wb_dout_sel),
      .epu_wb_valid    (epu_wb_valid),
      .exc_flush       (exc_flush),
      .refetch         (refetch),
      .exc_flush_tgt   (exc_flush_tgt),
      .msr_psr         (msr_psr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic msr_state_t reset_state();
      msr_state_t s;
      s = '0;
      // Only rm is set out of reset
      s.psr = 6'b000001;
      return s;
   endfunction

   function automatic expect_t ref_commit(input op_t op, input msr_state_t cur);
      expect_t    e;
      logic [2:0] bank;
      logic [4:0] off;
      logic [4:0] we;
      logic [7:0] vect;
      data_t      pc4;
      data_t      npc4;
      logic       save;
      e = '0;
      bank = op.addr[11:9];
      off = op.addr[4:0];
      pc4 = {op.pc, 2'b00};
      npc4 = {op.npc, 2'b00};
      we = (op.wmsr && bank == 3'd0) ? off : 5'd0;
      if (bank == 3'd0)
      begin
         if (off[MSR_PSR])
            e.dout |= {22'd0, cur.psr, 4'd0};
         if (off[MSR_EPSR])
            e.dout |= {22'd0, cur.epsr, 4'd0};
         if (off[MSR_EPC])
            e.dout |= cur.epc;
         if (off[MSR_ELSA])
            e.dout |= cur.elsa;
         if (off[MSR_EVECT])
            e.dout |= {cur.evect, 8'd0};
      end
      e.dout_sel = op.rmsr;
      e.refetch = we[MSR_PSR];
      e.flush = |op.cause;
      vect = op.cause[CAUSE_SYSCALL] ? SYSCALL_V :
             op.cause[CAUSE_EINSN]   ? EINSN_V   :
             op.cause[CAUSE_EIRQ]    ? EIRQ_V    : EALIGN_V;
      e.tgt = op.cause[CAUSE_ERET] ? cur.epc[31:2] : {cur.evect, vect[7:2]};
      // Register updates at the end of the commit cycle
      e.nxt = cur;
      save = (|op.cause) && !op.cause[CAUSE_ERET];
      if (save)
      begin
         e.nxt.epsr = cur.psr;
         e.nxt.psr = {cur.psr[5:4], 3'b000, 1'b1};
      end
      else if (op.cause[CAUSE_ERET])
         e.nxt.psr = cur.epsr;
      else
      begin
         if (we[MSR_PSR])
            e.nxt.psr = op.wdat[9:4];
         if (we[MSR_EPSR])
            e.nxt.epsr = op.wdat[9:4];
      end
      if (we[MSR_EVECT])
         e.nxt.evect = op.wdat[31:8];
      if (we[MSR_EPC])
         e.nxt.epc = op.wdat;
      else if (save)
         e.nxt.epc = op.cause[CAUSE_SYSCALL] ? npc4 : pc4;
      if (op.cause[CAUSE_EINSN])
         e.nxt.elsa = pc4;
      else if (op.cause[CAUSE_EALIGN])
         e.nxt.elsa = op.vaddr;
      else if (we[MSR_ELSA])
         e.nxt.elsa = op.wdat;
      return e;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic data_t ps_addr(input int idx);
      return data_t'(1 << idx);
   endfunction

   function automatic op_t read_op(input data_t addr);
      op_t op;
      op = '0;
      op.rmsr = 1'b1;
      op.addr = addr;
      return op;
   endfunction

   function automatic op_t write_op(input int idx, input data_t wdat);
      op_t op;
      op = '0;
      op.wmsr = 1'b1;
      op.addr = ps_addr(idx);
      op.wdat = wdat;
      return op;
   endfunction

   function automatic op_t excp_op(input int cause_idx);
      op_t op;
      op = '0;
      op.cause[cause_idx] = 1'b1;
      op.pc = pc_t'($urandom);
      op.npc = op.pc + pc_t'(1);
      op.vaddr = $urandom;
      return op;
   endfunction

   // Capture, optional stall, then one commit cycle
   task automatic run_op(input op_t op, input int stall);
      @(posedge clk);
      cmt_req_valid <= 1'b1;
      cmt_exc       <= |op.cause[CAUSE_EIRQ:CAUSE_ERET];
      cmt_fe        <= op.cause & ~cause_t'(1 << CAUSE_EALIGN);
      cmt_rmsr      <= op.rmsr;
      cmt_wmsr      <= op.wmsr;
      cmt_addr      <= op.addr;
      cmt_wdat      <= op.wdat;
      cmt_pc        <= op.pc;
      cmt_npc       <= op.npc;
      @(posedge clk);
      cmt_req_valid <= 1'b0;
      cmt_exc       <= 1'b0;
      cmt_fe        <= '0;
      cmt_rmsr      <= 1'b0;
      cmt_wmsr      <= 1'b0;
      if (stall > 0)
      begin
         p_ce_s1 <= 1'b0;
         p_ce_s2 <= 1'b0;
         repeat (stall) @(posedge clk);
         p_ce_s1 <= 1'b1;
         p_ce_s2 <= 1'b1;
      end
      // Stage-three fault arrives with the commit cycle
      s3i_ealign <= op.cause[CAUSE_EALIGN];
      s3i_vaddr  <= op.vaddr;
      expect_q   <= ref_commit(op, model);
      in_commit  <= 1'b1;
      requests++;
      @(posedge clk);
      s3i_ealign <= 1'b0;
      in_commit  <= 1'b0;
      model      <= expect_q.nxt;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Comparison
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string what, input data_t got, input data_t exp);
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
   endtask

   always @(negedge clk)
   begin
      if (!reset)
      begin
         checks++;
         if (in_commit)
         begin
            if (epu_wb_valid !== 1'b1)
               report_mismatch("epu_wb_valid", data_t'(epu_wb_valid), 32'd1);
            if (epu_wb_dout_sel !== expect_q.dout_sel)
               report_mismatch("epu_wb_dout_sel", data_t'(epu_wb_dout_sel),
                               data_t'(expect_q.dout_sel));
            if (expect_q.dout_sel && epu_wb_dout !== expect_q.dout)
               report_mismatch("epu_wb_dout", epu_wb_dout, expect_q.dout);
            if (exc_flush !== expect_q.flush)
               report_mismatch("exc_flush", data_t'(exc_flush), data_t'(expect_q.flush));
            if (expect_q.flush && exc_flush_tgt !== expect_q.tgt)
               report_mismatch("exc_flush_tgt", data_t'(exc_flush_tgt), data_t'(expect_q.tgt));
            if (refetch !== expect_q.refetch)
               report_mismatch("refetch", data_t'(refetch), data_t'(expect_q.refetch));
         end
         else if (epu_wb_valid !== 1'b0 || exc_flush !== 1'b0 || refetch !== 1'b0)
            report_mismatch("commit outputs outside a commit",
                            data_t'({epu_wb_valid, exc_flush, refetch}), 32'd0);
         if (msr_psr !== model.psr)
            report_mismatch("msr_psr", data_t'(msr_psr), data_t'(model.psr));
         if (epu_wb_valid === 1'b1)
            commits++;
      end
   end

   // Watchdog
   initial
   begin
      #(WATCH_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", WATCH_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin : main_seq
      int  total_errors;
      int  kind;
      int  idx;
      int  stall;
      int  n;
      op_t op;
      void'($urandom(73));
      reset         <= 1'b1;
      p_ce_s1       <= 1'b1;
      p_ce_s2       <= 1'b1;
      cmt_req_valid <= 1'b0;
      cmt_exc       <= 1'b0;
      cmt_rmsr      <= 1'b0;
      cmt_wmsr      <= 1'b0;
      s3i_ealign    <= 1'b0;
      cmt_fe        <= '0;
      cmt_pc        <= '0;
      cmt_npc       <= '0;
      cmt_addr      <= '0;
      cmt_wdat      <= '0;
      s3i_vaddr     <= '0;
      in_commit     <= 1'b0;
      expect_q      <= '0;
      model         <= reset_state();
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // PSR out of reset
      run_op(read_op(ps_addr(MSR_PSR)), 0);

      // Write and read back EPSR, EPC, ELSA, EVECT
      for (idx = MSR_EPSR; idx <= MSR_EVECT; idx++)
         run_op(write_op(idx, $urandom), 0);
      for (idx = MSR_EPSR; idx <= MSR_EVECT; idx++)
         run_op(read_op(ps_addr(idx)), 0);
      // Bank 3 reads as zero
      run_op(read_op(32'h0000_0604), 0);

      // PSR write and refetch
      run_op(write_op(MSR_PSR, $urandom), 0);
      run_op(read_op(ps_addr(MSR_PSR)), 0);

      // Synchronous exceptions through the vector base
      run_op(write_op(MSR_EVECT, $urandom), 0);
      for (n = CAUSE_SYSCALL; n <= CAUSE_EIRQ; n++)
      begin
         run_op(excp_op(n), 0);
         for (idx = MSR_EPSR; idx <= MSR_ELSA; idx++)
            run_op(read_op(ps_addr(idx)), 0);
      end

      // ERET, then an alignment fault
      run_op(write_op(MSR_EPSR, $urandom), 0);
      run_op(write_op(MSR_EPC, $urandom), 0);
      run_op(excp_op(CAUSE_ERET), 0);
      run_op(read_op(ps_addr(MSR_PSR)), 0);
      run_op(excp_op(CAUSE_EALIGN), 0);
      run_op(read_op(ps_addr(MSR_ELSA)), 0);

      // Random mix with stalls
      for (n = 0; n < NUM_RANDOM; n++)
      begin
         kind = int'($urandom_range(2, 0));
         idx = int'($urandom_range(4, 0));
         if (kind == 0)
            op = read_op(ps_addr(idx));
         else if (kind == 1)
            op = write_op(idx, $urandom);
         else
            op = excp_op(int'($urandom_range(4, 0)));
         stall = ($urandom_range(1, 0) == 1) ? int'($urandom_range(4, 1)) : 0;
         run_op(op, stall);
      end

      repeat (2) @(posedge clk);
      total_errors = errors;
      if (commits != requests)
      begin
         total_errors++;
         $display("FAIL %0t: %0d commits seen for %0d requests", $time, commits, requests);
      end
      $display("Checks: %0d, requests: %0d, commits: %0d, errors: %0d",
               checks, requests, commits, total_errors);
      if (total_errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: epu_top.f
src/epu_pkg.sv
src/epu_commit_if.sv
src/epu_msr_if.sv
src/epu_msr_decode.sv
src/epu_commit_ctrl.sv
src/epu_excp_regs.sv
src/epu_excp_addr.sv
src/epu_top.sv
bench/epu_tb.sv

// File: Makefile
TOP = epu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f epu_top.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
